// File: hw/alut_pkg.sv
/* alut shared definitions
   widths, table entry, request/result words and the mac hash */
`default_nettype none

package alut_pkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int mac_w   = 48;
   localparam int port_w  = 2;
   localparam int stamp_w = 32;
   localparam int addr_w  = 8;
   localparam int tbl_depth = 2 ** addr_w;  // direct mapped, one entry per hash

   // one table word, 83 bits
   typedef struct packed {
      logic               valid;
      logic [stamp_w-1:0] stamp;   // time of last learn
      logic [port_w-1:0]  port;
      logic [mac_w-1:0]   mac;
   } alut_entry_t;

   // lookup request as seen on the port
   typedef struct packed {
      logic [mac_w-1:0]  src_mac;
      logic [mac_w-1:0]  dst_mac;
      logic [port_w-1:0] src_port;
   } alut_req_t;

   typedef struct packed {
      logic              hit;
      logic              broadcast;
      logic [port_w-1:0] dst_port;  // zero on broadcast
   } alut_res_t;

   // single access to one memory port
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic              write;     // 1 write, 0 read
      alut_entry_t       wdata;
   } mem_port_t;

   // xor fold of the six mac bytes
   function automatic logic [addr_w-1:0] alut_hash(input logic [mac_w-1:0] mac);
      logic [addr_w-1:0] h;
      h = '0;
      for (int i = 0; i < mac_w / 8; i++)
      begin
         h ^= mac[8*i +: 8];
      end
      return h;
   endfunction

endpackage

`default_nettype wire

// File: hw/alut_mem.sv
/* alut table memory
   256 x 83 two-port ram, registered reads, address checker and age checker ports */
`default_nettype none

module alut_mem (
   input  wire                     pclk29,
   input  wire  alut_pkg::mem_port_t add_port,   // address checker side
   input  wire  alut_pkg::mem_port_t age_port,   // age checker side
   output alut_pkg::alut_entry_t   add_rdata,
   output alut_pkg::alut_entry_t   age_rdata
);

   import alut_pkg::*;

   alut_entry_t mem_q [tbl_depth];  // no reset, cleared by the age checker

   // ------------------------------
   // port access
   // ------------------------------
   // a port either writes or reads in a given cycle, read data one cycle later
   // read data holds its last value across a write cycle
   always_ff @(posedge pclk29)
   begin
      if (age_port.write)
      begin
         mem_q[age_port.addr] <= age_port.wdata;  // clear / invalidate
      end
      else
      begin
         age_rdata <= mem_q[age_port.addr];
      end

      // learn write placed last, wins on a same-index write
      if (add_port.write)
      begin
         mem_q[add_port.addr] <= add_port.wdata;
      end
      else
      begin
         add_rdata <= mem_q[add_port.addr];       // dst lookup
      end
   end

endmodule

`default_nettype wire

// File: hw/alut_addr_fsm.sv
/* address checker sequencer
   idle -> read_dst -> compare -> done, one lookup plus one learn per request */
`default_nettype none

module alut_addr_fsm (
   input  wire  pclk29,
   input  wire  arst_n,
   input  wire  req,          // request pulse
   input  wire  init_done,    // table cleared, lookups allowed
   output logic capture,      // latch frame
   output logic rd_dst,       // issue dst read
   output logic learn,        // write src entry
   output logic set_result,   // register compare outcome
   output logic busy,         // to age checker
   output logic result_valid
);

   typedef enum logic [1:0] {
      st_idle,
      st_read_dst,
      st_compare,
      st_done
   } state_t;

   state_t state_q;
   state_t state_d;
   logic   start;

   // request only taken when idle and the table is ready
   // anything arriving while busy is dropped
   assign start = (state_q == st_idle) && req && init_done;

   // ------------------------------
   // next state
   // ------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         st_idle:
         begin
            if (start)
            begin
               state_d = st_read_dst;
            end
         end
         st_read_dst: state_d = st_compare;  // ram read in flight
         st_compare:  state_d = st_done;     // data back, learn goes out
         st_done:     state_d = st_idle;
         default:     state_d = st_idle;
      endcase
   end

   always_ff @(posedge pclk29 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state_q <= st_idle;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // ------------------------------
   // strobes
   // ------------------------------
   // all decoded from the state register, no combinational paths from req
   // except capture, which must grab the frame on the accepting edge
   assign capture      = start;
   assign rd_dst       = (state_q == st_read_dst);
   assign set_result   = (state_q == st_compare);
   assign learn        = (state_q == st_compare);   // same cycle as compare
   assign busy         = (state_q != st_idle);      // keeps age pairs off the table
   assign result_valid = (state_q == st_done);      // one cycle, 3 after req

endmodule

`default_nettype wire

// File: hw/alut_addr_path.sv
/* address checker datapath
   frame capture, hashing, destination compare, result register, learned entry */
`default_nettype none

module alut_addr_path (
   input  wire                            pclk29,
   input  wire                            arst_n,
   input  wire  alut_pkg::alut_req_t      req_frame,
   input  wire  [alut_pkg::stamp_w-1:0]   now_stamp,
   input  wire                            capture,
   input  wire                            rd_dst,
   input  wire                            learn,
   input  wire                            set_result,
   input  wire  alut_pkg::alut_entry_t    add_rdata,
   output alut_pkg::mem_port_t            add_port,
   output alut_pkg::alut_res_t            result
);

   import alut_pkg::*;

   alut_req_t         frame_q;    // held for the whole lookup
   logic [addr_w-1:0] dst_idx;
   logic [addr_w-1:0] src_idx;
   alut_entry_t       learn_entry;
   logic              dst_hit;

   // ------------------------------
   // frame capture
   // ------------------------------
   always_ff @(posedge pclk29)
   begin
      if (capture)
      begin
         frame_q <= req_frame;
      end
   end

   assign dst_idx = alut_hash(frame_q.dst_mac);
   assign src_idx = alut_hash(frame_q.src_mac);

   // fresh entry for the source, overwrites whatever sits at its hash
   always_comb
   begin
      learn_entry.valid = 1'b1;
      learn_entry.stamp = now_stamp;
      learn_entry.port  = frame_q.src_port;
      learn_entry.mac   = frame_q.src_mac;
   end

   // ------------------------------
   // memory port
   // ------------------------------
   always_comb
   begin
      add_port.addr  = '0;
      add_port.write = 1'b0;
      add_port.wdata = learn_entry;
      if (rd_dst)
      begin
         add_port.addr = dst_idx;   // lookup read
      end
      if (learn)
      begin
         add_port.addr  = src_idx;  // learn write
         add_port.write = 1'b1;
      end
   end

   // hit needs a valid entry holding exactly this mac, age not checked
   assign dst_hit = add_rdata.valid && (add_rdata.mac == frame_q.dst_mac);

   // ------------------------------
   // result register
   // ------------------------------
   always_ff @(posedge pclk29 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         result <= '0;
      end
      else if (set_result)
      begin
         result.hit       <= dst_hit;
         result.broadcast <= !dst_hit;
         result.dst_port  <= dst_hit ? add_rdata.port : '0;  // zero when flooding
      end
   end

endmodule

`default_nettype wire

// File: hw/alut_age_timer.sv
/* age timestamp
   prescaled free running stamp, tick on every increment */
`default_nettype none

module alut_age_timer #(
   parameter int AGE_PRESCALE = 16
) (
   input  wire                          pclk29,
   input  wire                          arst_n,
   output logic [alut_pkg::stamp_w-1:0] now_stamp,
   output logic                         tick
);

   localparam int pre_w = (AGE_PRESCALE > 1) ? $clog2(AGE_PRESCALE) : 1;

   logic [pre_w-1:0] pre_q;   // prescale count
   logic             wrap;

   assign wrap = (pre_q == pre_w'(AGE_PRESCALE - 1));

   always_ff @(posedge pclk29 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pre_q     <= '0;
         now_stamp <= '0;
         tick      <= 1'b0;
      end
      else
      begin
         pre_q <= wrap ? '0 : pre_q + 1'b1;
         tick  <= wrap;                       // lines up with the new stamp
         if (wrap)
         begin
            now_stamp <= now_stamp + 1'b1;    // wraps after 2^32 periods
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/alut_age_chk.sv
/* age checker
   clears the table after reset, then sweeps it per tick and drops stale entries */
`default_nettype none

module alut_age_chk (
   input  wire                            pclk29,
   input  wire                            arst_n,
   input  wire                            busy,           // lookup in progress
   input  wire                            tick,
   input  wire  [alut_pkg::stamp_w-1:0]   now_stamp,
   input  wire  [alut_pkg::stamp_w-1:0]   age_threshold,
   input  wire  alut_pkg::alut_entry_t    age_rdata,
   output alut_pkg::mem_port_t            age_port,
   output logic                           init_done
);

   import alut_pkg::*;

   typedef enum logic [1:0] {
      ph_clear,   // one invalid write per index
      ph_wait,    // waiting for a tick
      ph_sweep    // read / check pairs
   } phase_t;

   phase_t            phase_q;
   logic [addr_w-1:0] idx_q;
   logic              rd_pend_q;   // read issued last cycle, data on age_rdata
   logic              stale;
   logic              last_idx;

   // stamp difference is modular, so a wrapped stamp still ages right
   assign stale    = age_rdata.valid && ((now_stamp - age_rdata.stamp) > age_threshold);
   assign last_idx = (idx_q == '1);

   // ------------------------------
   // memory port
   // ------------------------------
   always_comb
   begin
      age_port.addr  = idx_q;
      age_port.write = 1'b0;
      age_port.wdata = '0;          // invalid entry
      case (phase_q)
         ph_clear: age_port.write = 1'b1;
         ph_sweep:
         begin
            // invalidate only when the lookup side stayed quiet both cycles
            if (rd_pend_q && !busy && stale)
            begin
               age_port.write = 1'b1;
            end
         end
         default: age_port.write = 1'b0;
      endcase
   end

   // ------------------------------
   // phase and index
   // ------------------------------
   always_ff @(posedge pclk29 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         phase_q   <= ph_clear;
         idx_q     <= '0;
         rd_pend_q <= 1'b0;
         init_done <= 1'b0;
      end
      else
      begin
         case (phase_q)
            ph_clear:
            begin
               idx_q <= idx_q + 1'b1;
               if (last_idx)
               begin
                  phase_q   <= ph_wait;
                  init_done <= 1'b1;   // lookups may start now
               end
            end
            ph_wait:
            begin
               rd_pend_q <= 1'b0;
               if (tick)
               begin
                  phase_q <= ph_sweep;   // idx already back at 0
               end
            end
            ph_sweep:
            begin
               // ticks are ignored here
               if (!rd_pend_q)
               begin
                  rd_pend_q <= !busy;    // read only while idle
               end
               else
               begin
                  rd_pend_q <= 1'b0;
                  if (!busy)
                  begin
                     idx_q <= idx_q + 1'b1;
                     if (last_idx)
                     begin
                        phase_q <= ph_wait;
                     end
                  end
                  // busy rose between read and check, retry same index
               end
            end
            default: phase_q <= ph_wait;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/alut_top.sv
/* alut top
   address checker, age checker, timer and table memory */
`default_nettype none

module alut_top #(
   parameter int AGE_PRESCALE = 16    // cycles per timestamp step
) (
   input  wire                            pclk29,
   input  wire                            arst_n,
   input  wire                            req,
   input  wire  alut_pkg::alut_req_t      req_frame,
   input  wire  [alut_pkg::stamp_w-1:0]   age_threshold,
   output logic                           ready,
   output logic                           result_valid,
   output alut_pkg::alut_res_t            result
);

   import alut_pkg::*;

   // ------------------------------
   // internal wiring
   // ------------------------------
   logic capture;
   logic rd_dst;
   logic learn;
   logic set_result;
   logic busy;
   logic init_done;
   logic tick;

   logic [stamp_w-1:0] now_stamp;
   mem_port_t          add_port;
   mem_port_t          age_port;
   alut_entry_t        add_rdata;
   alut_entry_t        age_rdata;

   assign ready = init_done;   // high once the clear pass is over

   alut_addr_fsm addr_fsm_i (
      .pclk29       (pclk29),
      .arst_n       (arst_n),
      .req          (req),
      .init_done    (init_done),
      .capture      (capture),
      .rd_dst       (rd_dst),
      .learn        (learn),
      .set_result   (set_result),
      .busy         (busy),
      .result_valid (result_valid)
   );

   alut_addr_path addr_path_i (
      .pclk29     (pclk29),
      .arst_n     (arst_n),
      .req_frame  (req_frame),
      .now_stamp  (now_stamp),
      .capture    (capture),
      .rd_dst     (rd_dst),
      .learn      (learn),
      .set_result (set_result),
      .add_rdata  (add_rdata),
      .add_port   (add_port),
      .result     (result)
   );

   alut_age_timer #(
      .AGE_PRESCALE (AGE_PRESCALE)
   ) age_timer_i (
      .pclk29    (pclk29),
      .arst_n    (arst_n),
      .now_stamp (now_stamp),
      .tick      (tick)
   );

   alut_age_chk age_chk_i (
      .pclk29        (pclk29),
      .arst_n        (arst_n),
      .busy          (busy),
      .tick          (tick),
      .now_stamp     (now_stamp),
      .age_threshold (age_threshold),
      .age_rdata     (age_rdata),
      .age_port      (age_port),
      .init_done     (init_done)
   );

   alut_mem mem_i (
      .pclk29    (pclk29),
      .add_port  (add_port),
      .age_port  (age_port),
      .add_rdata (add_rdata),
      .age_rdata (age_rdata)
   );

endmodule

`default_nettype wire

// File: tests/alut_chk.sv
/* alut strobe assertions
   result pulse width, fixed latency, ready held low during the clear */
`default_nettype none

module alut_chk (
   input logic pclk29,
   input logic arst_n,
   input logic req,
   input logic ready,
   input logic busy,
   input logic result_valid
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [8:0]  since_rst_q;      // saturates at 256
   int unsigned fail_cnt = 0;     // read by the testbench

   always_ff @(posedge pclk29 or negedge arst_n)
   begin
      if (!arst_n)
      begin
         since_rst_q <= '0;
      end
      else if (since_rst_q != 9'd256)
      begin
         since_rst_q <= since_rst_q + 1'b1;
      end
   end

   // ------------------------------
   // properties
   // ------------------------------
   pulse_a : assert property (@(posedge pclk29) disable iff (!arst_n)
      result_valid |=> !result_valid)
   else
   begin
      fail_cnt++;
      $error("result_valid longer than one cycle");
   end

   latency_a : assert property (@(posedge pclk29) disable iff (!arst_n)
      (req && ready && !busy) |-> ##3 result_valid)
   else
   begin
      fail_cnt++;
      $error("result_valid not 3 cycles after an accepted request");
   end

   clear_a : assert property (@(posedge pclk29) disable iff (!arst_n)
      (since_rst_q < 9'd256) |-> !ready)
   else
   begin
      fail_cnt++;
      $error("ready high during the table clear");
   end

endmodule

bind alut_top alut_chk chk_i (
   .pclk29       (pclk29),
   .arst_n       (arst_n),
   .req          (req),
   .ready        (ready),
   .busy         (busy),
   .result_valid (result_valid)
);

`default_nettype wire

// File: tests/alut_tb.sv
/* alut testbench
   random lookups against a reference table model, aging and timeout */
`default_nettype none

module alut_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import alut_pkg::*;

   localparam int AGE_PRESCALE = 4;
   localparam int idle_cycles  = 4 * AGE_PRESCALE * (2 + 2) + 1100;  // threshold, slack, 2 sweeps
   // clear + reset, ~220 requests at 5 cycles, two aging waits, then a wide margin
   localparam int max_cycles   = 20000;

   logic                pclk29;
   logic                arst_n;
   logic                req;
   alut_req_t           req_frame;
   logic [stamp_w-1:0]  age_threshold;
   logic                ready;
   logic                result_valid;
   alut_res_t           result;

   // reference table model
   logic                model_valid [256];
   logic [47:0]         model_mac   [256];
   logic [1:0]          model_port  [256];

   alut_res_t           exp_q[$];     // expected results in request order
   logic [47:0]         learned_q[$]; // every src mac sent so far
   int                  err_cnt = 0;
   int                  cyc_cnt = 0;

   alut_top #(
      .AGE_PRESCALE (AGE_PRESCALE)
   ) dut_i (
      .pclk29        (pclk29),
      .arst_n        (arst_n),
      .req           (req),
      .req_frame     (req_frame),
      .age_threshold (age_threshold),
      .ready         (ready),
      .result_valid  (result_valid),
      .result        (result)
   );

   initial
   begin
      pclk29 = 1'b0;
      forever #10 pclk29 = ~pclk29;  // 20 ns period
   end

   // ------------------------------
   // model
   // ------------------------------
   function automatic logic [7:0] hash_mac(input logic [47:0] mac);
      logic [7:0] h;
      h = mac[7:0] ^ mac[15:8] ^ mac[23:16] ^ mac[31:24] ^ mac[39:32] ^ mac[47:40];
      return h;
   endfunction

   // lookup against the table as it stands before this request learns
   function automatic alut_res_t predict_result(input logic [47:0] dst);
      alut_res_t  r;
      logic [7:0] idx;
      idx = hash_mac(dst);
      r   = '0;
      if (model_valid[idx] && (model_mac[idx] == dst))
      begin
         r.hit      = 1'b1;
         r.dst_port = model_port[idx];
      end
      else
      begin
         r.broadcast = 1'b1;  // port stays 0
      end
      return r;
   endfunction

   task automatic learn_entry(input logic [47:0] src, input logic [1:0] port);
      logic [7:0] idx;
      idx = hash_mac(src);
      model_valid[idx] = 1'b1;  // newer entry replaces the slot
      model_mac[idx]   = src;
      model_port[idx]  = port;
   endtask

   task automatic clear_model();
      for (int i = 0; i < 256; i++)
      begin
         model_valid[i] = 1'b0;
      end
   endtask

   function automatic logic [47:0] rand_mac();
      logic [47:0] m;
      m[47:32] = $urandom;
      m[31:0]  = $urandom;
      return m;
   endfunction

   // ------------------------------
   // checking
   // ------------------------------
   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
      begin
         err_cnt++;
         $display("[ERROR] %0d ns: %s got %h expected %h", $time, what, got, exp);
         $display("sim failed");
         $fatal(1, "value mismatch");
      end
   endtask

   always @(negedge pclk29)
   begin
      if (arst_n && result_valid)
      begin
         if (exp_q.size() == 0)
         begin
            err_cnt++;
            $display("a result came back with no request outstanding at %0d ns", $time);
            $display("sim failed");
            $fatal(1, "unexpected result");
         end
         else
         begin
            check_equal(32'(result), 32'(exp_q.pop_front()), "lookup result");
         end
      end
   end

   // strobe assertions in the bound checker count their failures
   always @(negedge pclk29)
   begin
      if (dut_i.chk_i.fail_cnt != 0)
      begin
         $display("a strobe assertion on the dut failed at %0d ns", $time);
         $display("sim failed");
         $fatal(1, "assertion failure");
      end
   end

   always @(posedge pclk29)
   begin
      cyc_cnt++;
      if (cyc_cnt >= max_cycles)
      begin
         $display("the run did not finish within %0d clock cycles", max_cycles);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   // one request, returns on the negedge where result_valid is seen
   task automatic send_request(input logic [47:0] src, input logic [47:0] dst,
                               input logic [1:0] port);
      exp_q.push_back(predict_result(dst));
      learn_entry(src, port);
      learned_q.push_back(src);
      @(negedge pclk29);           // fsm back in idle by now
      req                = 1'b1;
      req_frame.src_mac  = src;
      req_frame.dst_mac  = dst;
      req_frame.src_port = port;
      @(negedge pclk29);
      req = 1'b0;
      while (!result_valid)
      begin
         @(negedge pclk29);
      end
   endtask

   // let every entry age out, then mirror it in the model
   task automatic age_out();
      age_threshold = 32'd2;
      repeat (idle_cycles) @(negedge pclk29);
      clear_model();
   endtask

   initial
   begin
      logic [47:0]  mac_a;
      logic [47:0]  mac_b;
      logic [47:0]  src;
      logic [47:0]  dst;
      logic [1:0]   port_p;
      logic [47:0]  old_q[$];
      logic [47:0]  pool_q[$];

      void'($urandom(32'h1a952973));
      arst_n        = 1'b0;
      req           = 1'b0;
      req_frame     = '0;
      age_threshold = '1;            // nothing ages
      clear_model();
      repeat (4) @(negedge pclk29);
      arst_n = 1'b1;
      while (!ready)
      begin
         @(negedge pclk29);          // table clear pass
      end

      // unknown dst floods
      send_request(rand_mac(), rand_mac(), 2'($urandom));

      // learn A on p, then look it up
      mac_a  = rand_mac();
      port_p = 2'($urandom);
      send_request(mac_a, rand_mac(), port_p);
      send_request(rand_mac(), mac_a, 2'($urandom));

      // A moves to another port
      send_request(mac_a, rand_mac(), port_p + 2'd1);
      send_request(rand_mac(), mac_a, 2'($urandom));
      send_request(rand_mac(), mac_a, 2'($urandom));

      // B shares the hash of A, bytes 0 and 1 flipped alike
      mac_b = mac_a ^ 48'h0000_0000_5a5a;
      send_request(mac_b, rand_mac(), 2'($urandom));
      send_request(rand_mac(), mac_a, 2'($urandom));
      send_request(rand_mac(), mac_b, 2'($urandom));

      // aging, all older macs must flood
      old_q = learned_q;
      age_out();
      foreach (old_q[i])
      begin
         send_request(rand_mac(), old_q[i], 2'($urandom));
      end
      age_out();                     // drop what the checks above learned
      age_threshold = '1;

      // random mix of reused and fresh macs
      for (int n = 0; n < 200; n++)
      begin
         if ((pool_q.size() > 0) && ($urandom_range(1, 0) == 1))
         begin
            src = pool_q[$urandom_range(pool_q.size() - 1, 0)];
         end
         else
         begin
            src = rand_mac();
            pool_q.push_back(src);
         end
         if ((pool_q.size() > 0) && ($urandom_range(4, 0) < 3))
         begin
            dst = pool_q[$urandom_range(pool_q.size() - 1, 0)];
         end
         else
         begin
            dst = rand_mac();
         end
         send_request(src, dst, 2'($urandom));
      end

      repeat (4) @(negedge pclk29);  // last compare done
      if ((err_cnt == 0) && (dut_i.chk_i.fail_cnt == 0) && (exp_q.size() == 0))
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
hw/alut_pkg.sv
hw/alut_mem.sv
hw/alut_addr_fsm.sv
hw/alut_addr_path.sv
hw/alut_age_timer.sv
hw/alut_age_chk.sv
hw/alut_top.sv
tests/alut_chk.sv
tests/alut_tb.sv
